//--- hw/rv32i_types.sv
package rv32i_types;

    // major opcodes, low seven bits of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // funct3 of op_imm and op_reg
    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef logic [4:0] reg_id_t;

    // control word carried down the pipe, one per instruction
    typedef struct packed {
        rv32i_opcode opcode;
        logic [2:0]  funct3;
        reg_id_t     rs1_id;
        reg_id_t     rs2_id;
        reg_id_t     rd_id;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
    } rv32i_control_word;

    // empty slot, all fields zero
    localparam rv32i_control_word ctrl_bubble = '0;

endpackage : rv32i_types

//--- hw/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // addi x0, x0, 0
    localparam instr_t nop_instr = 32'h00000013;

    // per-register load and flush strobes
    typedef struct packed {
        logic load_pc;
        logic if_id_reg_load;
        logic id_ex_reg_load;
        logic ex_mem_reg_load;
        logic mem_wb_reg_load;
        logic if_id_reg_flush;
        logic id_ex_reg_flush;
        logic ex_mem_reg_flush;
        logic mem_wb_reg_flush;
    } stage_ctrl_t;

endpackage : pipe_ctrl_pkg

//--- hw/control_decoder.sv
module control_decoder
(
    input  pipe_ctrl_pkg::instr_t          if_id_instr,
    output rv32i_types::rv32i_control_word id_ex_in_ctrl
);

    rv32i_types::rv32i_opcode opcode;
    logic                     has_rs1;
    logic                     has_rs2;
    logic                     has_rd;
    logic                     has_funct3;
    logic                     known_fmt;

    assign opcode = rv32i_types::rv32i_opcode'(if_id_instr[6:0]);

    // which fields the format actually carries
    always_comb
    begin
        has_rs1    = 1'b1;
        has_rs2    = 1'b0;
        has_rd     = 1'b1;
        has_funct3 = 1'b1;
        known_fmt  = 1'b1;
        case (opcode)
            rv32i_types::op_lui, rv32i_types::op_auipc, rv32i_types::op_jal:
            begin
                // U and J formats, no sources
                has_rs1    = 1'b0;
                has_funct3 = 1'b0;
            end
            rv32i_types::op_br, rv32i_types::op_store:
            begin
                has_rs2 = 1'b1;
                has_rd  = 1'b0;
            end
            rv32i_types::op_reg:
            begin
                has_rs2 = 1'b1;
            end
            rv32i_types::op_jalr, rv32i_types::op_load, rv32i_types::op_imm:
            begin
                known_fmt = 1'b1;
            end
            default:
            begin
                known_fmt = 1'b0;
            end
        endcase
    end

    // unused fields forced to zero so no phantom source can match
    always_comb
    begin
        id_ex_in_ctrl.opcode    = opcode;
        id_ex_in_ctrl.funct3    = has_funct3 ? if_id_instr[14:12] : 3'b000;
        id_ex_in_ctrl.rs1_id    = has_rs1 ? if_id_instr[19:15] : 5'd0;
        id_ex_in_ctrl.rs2_id    = has_rs2 ? if_id_instr[24:20] : 5'd0;
        id_ex_in_ctrl.rd_id     = has_rd ? if_id_instr[11:7] : 5'd0;
        id_ex_in_ctrl.mem_read  = (opcode == rv32i_types::op_load);
        id_ex_in_ctrl.mem_write = (opcode == rv32i_types::op_store);
        id_ex_in_ctrl.reg_write = has_rd && known_fmt;
    end

endmodule : control_decoder

//--- hw/fetch_stage.sv
module fetch_stage
#(
    parameter pipe_ctrl_pkg::addr_t RESET_PC = '0
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  pipe_ctrl_pkg::instr_t instr,
    input  pipe_ctrl_pkg::addr_t  redirect_target,
    input  logic                  load_pc,
    input  logic                  if_id_reg_load,
    input  logic                  if_id_reg_flush,
    output pipe_ctrl_pkg::addr_t  pc,
    output pipe_ctrl_pkg::instr_t if_id_instr
);

    // fetch pc, a redirect wins over the sequential step
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= RESET_PC;
        end
        else if (if_id_reg_flush)
        begin
            pc <= redirect_target;
        end
        else if (load_pc)
        begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID instruction register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            if_id_instr <= pipe_ctrl_pkg::nop_instr;
        end
        else if (if_id_reg_flush)
        begin
            // squash the wrong-path fetch
            if_id_instr <= pipe_ctrl_pkg::nop_instr;
        end
        else if (if_id_reg_load)
        begin
            if_id_instr <= instr;
        end
    end

endmodule : fetch_stage

//--- hw/control_pipeline.sv
module control_pipeline
(
    input  logic                           clk,
    input  logic                           reset,
    input  rv32i_types::rv32i_control_word id_ex_in_ctrl,
    input  logic                           id_ex_reg_load,
    input  logic                           ex_mem_reg_load,
    input  logic                           mem_wb_reg_load,
    input  logic                           id_ex_reg_flush,
    input  logic                           ex_mem_reg_flush,
    input  logic                           mem_wb_reg_flush,
    output rv32i_types::rv32i_control_word id_ex_out_ctrl,
    output rv32i_types::rv32i_control_word ex_mem_out_ctrl,
    output rv32i_types::rv32i_control_word mem_wb_out_ctrl
);

    localparam int N_STAGES = 3;

    rv32i_types::rv32i_control_word stage_in [N_STAGES];
    rv32i_types::rv32i_control_word stage_q  [N_STAGES];
    logic [N_STAGES-1:0]            stage_load;
    logic [N_STAGES-1:0]            stage_flush;

    // index 0 is ID/EX, 2 is MEM/WB
    assign stage_in[0] = id_ex_in_ctrl;
    assign stage_in[1] = stage_q[0];
    assign stage_in[2] = stage_q[1];

    assign stage_load  = {mem_wb_reg_load, ex_mem_reg_load, id_ex_reg_load};
    assign stage_flush = {mem_wb_reg_flush, ex_mem_reg_flush, id_ex_reg_flush};

    for (genvar i = 0; i < N_STAGES; i++)
    begin : g_stage
        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                stage_q[i] <= rv32i_types::ctrl_bubble;
            end
            else if (stage_flush[i])
            begin
                // flush beats load, inserts an empty slot
                stage_q[i] <= rv32i_types::ctrl_bubble;
            end
            else if (stage_load[i])
            begin
                stage_q[i] <= stage_in[i];
            end
        end
    end

    assign id_ex_out_ctrl  = stage_q[0];
    assign ex_mem_out_ctrl = stage_q[1];
    assign mem_wb_out_ctrl = stage_q[2];

endmodule : control_pipeline

//--- hw/stall_control_unit.sv
module stall_control_unit
(
    input  logic                           instr_mem_resp,
    input  logic                           data_mem_resp,
    input  rv32i_types::rv32i_control_word id_ex_in_ctrl,
    input  logic                           id_ex_in_br_en,
    input  rv32i_types::rv32i_control_word id_ex_out_ctrl,
    input  rv32i_types::rv32i_control_word ex_mem_out_ctrl,
    output pipe_ctrl_pkg::stage_ctrl_t     stage_ctrl
);

    logic decode_stall;
    logic execute_stall;
    logic redirect;
    logic instr_miss;
    logic data_miss;

    function automatic logic is_slt_op(input rv32i_types::rv32i_control_word cw);
        logic arith;
        logic cmp_funct;
        arith     = (cw.opcode == rv32i_types::op_reg) || (cw.opcode == rv32i_types::op_imm);
        cmp_funct = (rv32i_types::arith_funct3_t'(cw.funct3) == rv32i_types::slt) ||
                    (rv32i_types::arith_funct3_t'(cw.funct3) == rv32i_types::sltu);
        return arith && cmp_funct;
    endfunction

    // result comes from the comparator
    function automatic logic needs_compare(input rv32i_types::rv32i_control_word cw);
        return (cw.opcode == rv32i_types::op_br) || is_slt_op(cw);
    endfunction

    // result comes from the ALU, late in EX
    function automatic logic needs_alu(input rv32i_types::rv32i_control_word cw);
        logic arith;
        arith = (cw.opcode == rv32i_types::op_reg) || (cw.opcode == rv32i_types::op_imm);
        return (arith && !is_slt_op(cw)) || (cw.opcode == rv32i_types::op_auipc);
    endfunction

    // consumer reads a register the producer writes; jalr has no rs2
    function automatic logic uses(input rv32i_types::rv32i_control_word consumer,
                                  input rv32i_types::rv32i_control_word producer);
        logic rs1_hit;
        logic rs2_hit;
        rs1_hit = (producer.rd_id == consumer.rs1_id);
        rs2_hit = (producer.rd_id == consumer.rs2_id) &&
                  (consumer.opcode != rv32i_types::op_jalr);
        return (producer.rd_id != 5'd0) && (rs1_hit || rs2_hit);
    endfunction

    // A: compare or jalr in decode waits on an operand still in flight
    assign decode_stall =
        (needs_compare(id_ex_in_ctrl) || (id_ex_in_ctrl.opcode == rv32i_types::op_jalr)) &&
        (((needs_alu(id_ex_out_ctrl) || (id_ex_out_ctrl.opcode == rv32i_types::op_load)) &&
          uses(id_ex_in_ctrl, id_ex_out_ctrl)) ||
         ((ex_mem_out_ctrl.opcode == rv32i_types::op_load) &&
          uses(id_ex_in_ctrl, ex_mem_out_ctrl)));

    // B: load data not ready for the ALU op or store base behind it
    assign execute_stall =
        (ex_mem_out_ctrl.opcode == rv32i_types::op_load) &&
        ((needs_alu(id_ex_out_ctrl) && uses(id_ex_out_ctrl, ex_mem_out_ctrl)) ||
         ((id_ex_out_ctrl.opcode == rv32i_types::op_store) &&
          (ex_mem_out_ctrl.rd_id != 5'd0) &&
          (ex_mem_out_ctrl.rd_id == id_ex_out_ctrl.rs1_id)));

    // C: predicted not-taken, so taken branches and all jumps redirect
    assign redirect = ((id_ex_in_ctrl.opcode == rv32i_types::op_br) && id_ex_in_br_en) ||
                      (id_ex_in_ctrl.opcode == rv32i_types::op_jal) ||
                      (id_ex_in_ctrl.opcode == rv32i_types::op_jalr);

    assign instr_miss = !instr_mem_resp;
    assign data_miss  = !data_mem_resp && (ex_mem_out_ctrl.mem_read || ex_mem_out_ctrl.mem_write);

    always_comb
    begin
        stage_ctrl                 = '0;
        stage_ctrl.load_pc         = 1'b1;
        stage_ctrl.if_id_reg_load  = 1'b1;
        stage_ctrl.id_ex_reg_load  = 1'b1;
        stage_ctrl.ex_mem_reg_load = 1'b1;
        stage_ctrl.mem_wb_reg_load = 1'b1;

        if (decode_stall)
        begin
            stage_ctrl.load_pc         = 1'b0;
            stage_ctrl.if_id_reg_load  = 1'b0;
            stage_ctrl.id_ex_reg_flush = 1'b1;
        end

        if (execute_stall)
        begin
            stage_ctrl.load_pc          = 1'b0;
            stage_ctrl.if_id_reg_load   = 1'b0;
            stage_ctrl.id_ex_reg_load   = 1'b0;
            stage_ctrl.ex_mem_reg_flush = 1'b1;
        end

        if (redirect)
        begin
            stage_ctrl.if_id_reg_flush = 1'b1;
        end

        // a miss of either kind freezes every register
        if (instr_miss || data_miss)
        begin
            stage_ctrl = '0;
        end
    end

endmodule : stall_control_unit

//--- hw/hazard_core_top.sv
module hazard_core_top
#(
    parameter pipe_ctrl_pkg::addr_t RESET_PC = '0
)
(
    input  logic                           clk,
    input  logic                           reset,
    input  pipe_ctrl_pkg::instr_t          instr,
    input  logic                           instr_mem_resp,
    input  logic                           data_mem_resp,
    input  logic                           br_en,
    input  pipe_ctrl_pkg::addr_t           redirect_target,
    output pipe_ctrl_pkg::addr_t           pc,
    output pipe_ctrl_pkg::stage_ctrl_t     stage_ctrl,
    output rv32i_types::rv32i_control_word retire_ctrl
);

    pipe_ctrl_pkg::instr_t          if_id_instr;
    rv32i_types::rv32i_control_word id_ex_in_ctrl;
    rv32i_types::rv32i_control_word id_ex_out_ctrl;
    rv32i_types::rv32i_control_word ex_mem_out_ctrl;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clk             (clk),
        .reset           (reset),
        .instr           (instr),
        .redirect_target (redirect_target),
        .load_pc         (stage_ctrl.load_pc),
        .if_id_reg_load  (stage_ctrl.if_id_reg_load),
        .if_id_reg_flush (stage_ctrl.if_id_reg_flush),
        .pc              (pc),
        .if_id_instr     (if_id_instr)
    );

    control_decoder control_decoder_i (
        .if_id_instr   (if_id_instr),
        .id_ex_in_ctrl (id_ex_in_ctrl)
    );

    // MEM/WB output is the retiring instruction
    control_pipeline control_pipeline_i (
        .clk              (clk),
        .reset            (reset),
        .id_ex_in_ctrl    (id_ex_in_ctrl),
        .id_ex_reg_load   (stage_ctrl.id_ex_reg_load),
        .ex_mem_reg_load  (stage_ctrl.ex_mem_reg_load),
        .mem_wb_reg_load  (stage_ctrl.mem_wb_reg_load),
        .id_ex_reg_flush  (stage_ctrl.id_ex_reg_flush),
        .ex_mem_reg_flush (stage_ctrl.ex_mem_reg_flush),
        .mem_wb_reg_flush (stage_ctrl.mem_wb_reg_flush),
        .id_ex_out_ctrl   (id_ex_out_ctrl),
        .ex_mem_out_ctrl  (ex_mem_out_ctrl),
        .mem_wb_out_ctrl  (retire_ctrl)
    );

    stall_control_unit stall_control_unit_i (
        .instr_mem_resp  (instr_mem_resp),
        .data_mem_resp   (data_mem_resp),
        .id_ex_in_ctrl   (id_ex_in_ctrl),
        .id_ex_in_br_en  (br_en),
        .id_ex_out_ctrl  (id_ex_out_ctrl),
        .ex_mem_out_ctrl (ex_mem_out_ctrl),
        .stage_ctrl      (stage_ctrl)
    );

endmodule : hazard_core_top

//--- tb/hazard_tests.svh
function automatic pipe_ctrl_pkg::instr_t enc_r(input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
    return {7'b0, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic pipe_ctrl_pkg::instr_t enc_i(input logic [6:0] op, input logic [4:0] rd,
                                                input logic [4:0] rs1);
    return {12'b0, rs1, 3'b000, rd, op};
endfunction

function automatic pipe_ctrl_pkg::instr_t enc_load(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'b0, rs1, 3'b010, rd, 7'b0000011};
endfunction

// store base is rs1, data is rs2
function automatic pipe_ctrl_pkg::instr_t enc_store(input logic [4:0] rs1, input logic [4:0] rs2);
    return {7'b0, rs2, rs1, 3'b010, 5'b0, 7'b0100011};
endfunction

function automatic pipe_ctrl_pkg::instr_t enc_br(input logic [4:0] rs1, input logic [4:0] rs2);
    return {7'b0, rs2, rs1, 3'b000, 5'b0, 7'b1100011};
endfunction

function automatic pipe_ctrl_pkg::instr_t enc_jal(input logic [4:0] rd);
    return {20'b0, rd, 7'b1101111};
endfunction

// addi x0, x0 with the word index in the immediate
task automatic clear_imem();
    for (int i = 0; i < 64; i++)
        imem[i] = {6'(i), 6'b0, 5'b0, 3'b000, 5'b0, 7'b0010011};
endtask

// two-word program, then the counts of each stall kind
task automatic run_pair(input pipe_ctrl_pkg::instr_t prod, input pipe_ctrl_pkg::instr_t cons,
                        input int exp_a, input int exp_b, input int exp_redir);
    clear_imem();
    imem[0] = prod;
    imem[1] = cons;
    run_prog(SHORT_RUN);
    check_value("id_ex_flush_cycles", 64'(id_ex_flushes), 64'(exp_a));
    check_value("ex_mem_flush_cycles", 64'(ex_mem_flushes), 64'(exp_b));
    check_value("if_id_flush_cycles", 64'(if_id_flushes), 64'(exp_redir));
endtask

task automatic test_independent();
    clear_imem();
    for (int i = 0; i < 8; i++)
        imem[i] = enc_r(3'b000, 5'(i + 1), 5'd20, 5'd21);
    run_prog(SHORT_RUN);
    check_value("hold_cycles", 64'(hold_cycles), 64'd0);
    check_value("flush_cycles", 64'(id_ex_flushes + ex_mem_flushes + if_id_flushes), 64'd0);
    // reset nop retires at check 4, first fetched word one cycle later
    check_value("retired_count", 64'(retired.size()), 64'(SHORT_RUN - 3));
    check_value("first_retire", 64'(retired[1]), 64'(decode_ref(imem[0])));
endtask

task automatic test_decode_stalls();
    br_taken = 1'b0;
    run_pair(enc_r(3'b000, 5'd5, 5'd1, 5'd2), enc_br(5'd5, 5'd3), 1, 0, 0);
    run_pair(enc_load(5'd5, 5'd1), enc_br(5'd3, 5'd5), 2, 0, 0);
    run_pair(enc_r(3'b000, 5'd5, 5'd1, 5'd2), enc_r(3'b010, 5'd6, 5'd5, 5'd0), 1, 0, 0);
    // jalr also redirects, so its stall lasts one cycle
    run_pair(enc_r(3'b000, 5'd5, 5'd1, 5'd2), enc_i(7'b1100111, 5'd1, 5'd5), 1, 0, 1);
    run_pair(enc_r(3'b000, 5'd0, 5'd1, 5'd2), enc_br(5'd0, 5'd0), 0, 0, 0);
    run_pair(enc_r(3'b000, 5'd5, 5'd1, 5'd2), enc_br(5'd6, 5'd7), 0, 0, 0);
endtask

task automatic test_execute_stalls();
    run_pair(enc_load(5'd5, 5'd1), enc_r(3'b000, 5'd6, 5'd5, 5'd1), 0, 1, 0);
    run_pair(enc_load(5'd5, 5'd1), enc_store(5'd5, 5'd1), 0, 1, 0);
    run_pair(enc_load(5'd5, 5'd1), enc_store(5'd1, 5'd5), 0, 0, 0);
endtask

task automatic test_redirects();
    br_taken = 1'b1;
    run_pair(enc_r(3'b000, 5'd5, 5'd1, 5'd2), enc_br(5'd1, 5'd2), 0, 0, 1);
    run_pair(enc_r(3'b000, 5'd5, 5'd1, 5'd2), enc_jal(5'd1), 0, 0, 1);
    run_pair(enc_r(3'b000, 5'd5, 5'd1, 5'd2), enc_i(7'b1100111, 5'd1, 5'd3), 0, 0, 1);
    br_taken = 1'b0;
    run_pair(enc_r(3'b000, 5'd5, 5'd1, 5'd2), enc_br(5'd1, 5'd2), 0, 0, 0);
endtask

task automatic test_misses();
    rv32i_types::rv32i_control_word ref_seq [$];
    clear_imem();
    imem[0] = enc_load(5'd5, 5'd1);
    imem[1] = enc_r(3'b000, 5'd6, 5'd5, 5'd2);
    imem[2] = enc_store(5'd7, 5'd6);
    imem[3] = enc_load(5'd8, 5'd7);
    imem[4] = enc_store(5'd8, 5'd3);
    imem[5] = enc_br(5'd8, 5'd0);
    run_prog(REF_RUN);
    ref_seq = retired;
    imiss_pct = 30;
    dmiss_pct = 40;
    run_prog(MISS_RUN);
    if (hold_cycles == 0 || retired.size() < ref_seq.size())
    begin
        $display("Testbench failed");
        $fatal(1, "miss run produced no holds or retired too few instructions");
    end
    for (int i = 0; i < ref_seq.size(); i++)
        check_value("retire_sequence", 64'(retired[i]), 64'(ref_seq[i]));
    // data misses without a memory op in EX/MEM change nothing
    imiss_pct = 0;
    dmiss_pct = 50;
    clear_imem();
    run_prog(SHORT_RUN);
    check_value("hold_cycles", 64'(hold_cycles), 64'd0);
    dmiss_pct = 0;
endtask

//--- tb/hazard_core_tb.sv
module hazard_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam pipe_ctrl_pkg::addr_t RESET_PC    = 32'h0;
    localparam pipe_ctrl_pkg::addr_t JUMP_TARGET = 32'h80;

    // run lengths in cycles, each run also spends 4 cycles on reset
    localparam int SHORT_RUN  = 20;
    localparam int N_SHORT    = 15;
    localparam int REF_RUN    = 30;
    localparam int MISS_RUN   = 90;
    localparam int MAX_CYCLES = N_SHORT * (SHORT_RUN + 4) + REF_RUN + MISS_RUN + 8 + 100;

    logic                           clk;
    logic                           reset;
    pipe_ctrl_pkg::instr_t          instr;
    logic                           instr_mem_resp;
    logic                           data_mem_resp;
    logic                           br_en;
    pipe_ctrl_pkg::addr_t           redirect_target;
    pipe_ctrl_pkg::addr_t           pc;
    pipe_ctrl_pkg::stage_ctrl_t     stage_ctrl;
    rv32i_types::rv32i_control_word retire_ctrl;

    // instruction memory, indexed by the DUT pc
    pipe_ctrl_pkg::instr_t imem [64];

    logic   br_taken;
    int     imiss_pct;
    int     dmiss_pct;
    integer seed;
    int     cycle_count;

    // DUT activity seen during one run
    int id_ex_flushes;
    int ex_mem_flushes;
    int if_id_flushes;
    int hold_cycles;
    rv32i_types::rv32i_control_word retired [$];

    // shadow copy of the pipeline registers
    pipe_ctrl_pkg::addr_t           s_pc;
    pipe_ctrl_pkg::instr_t          s_ifid;
    rv32i_types::rv32i_control_word s_idex;
    rv32i_types::rv32i_control_word s_exmem;
    rv32i_types::rv32i_control_word s_memwb;
    logic                           retire_new;

    hazard_core_top #(
        .RESET_PC (RESET_PC)
    ) hazard_core_top_i (
        .clk             (clk),
        .reset           (reset),
        .instr           (instr),
        .instr_mem_resp  (instr_mem_resp),
        .data_mem_resp   (data_mem_resp),
        .br_en           (br_en),
        .redirect_target (redirect_target),
        .pc              (pc),
        .stage_ctrl      (stage_ctrl),
        .retire_ctrl     (retire_ctrl)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Testbench failed");
            $fatal(1, "run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("Fail %s: actual %0h, expected %0h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // reference decode, unused fields are zero
    function automatic rv32i_types::rv32i_control_word decode_ref(input pipe_ctrl_pkg::instr_t w);
        rv32i_types::rv32i_control_word cw;
        logic [6:0]                     op;
        op           = w[6:0];
        cw           = '0;
        cw.opcode    = rv32i_types::rv32i_opcode'(op);
        cw.funct3    = w[14:12];
        cw.rs1_id    = w[19:15];
        cw.rd_id     = w[11:7];
        cw.reg_write = 1'b1;
        if (op == rv32i_types::op_lui || op == rv32i_types::op_auipc || op == rv32i_types::op_jal)
        begin
            cw.funct3 = 3'b000;
            cw.rs1_id = 5'd0;
        end
        if (op == rv32i_types::op_br || op == rv32i_types::op_store || op == rv32i_types::op_reg)
        begin
            cw.rs2_id = w[24:20];
        end
        if (op == rv32i_types::op_br || op == rv32i_types::op_store)
        begin
            cw.rd_id     = 5'd0;
            cw.reg_write = 1'b0;
        end
        cw.mem_read  = (op == rv32i_types::op_load);
        cw.mem_write = (op == rv32i_types::op_store);
        return cw;
    endfunction

    function automatic logic arith_op(input rv32i_types::rv32i_control_word cw);
        return cw.opcode == rv32i_types::op_reg || cw.opcode == rv32i_types::op_imm;
    endfunction

    function automatic logic set_less(input rv32i_types::rv32i_control_word cw);
        return arith_op(cw) && (cw.funct3 == 3'b010 || cw.funct3 == 3'b011);
    endfunction

    function automatic logic reads_result(input rv32i_types::rv32i_control_word cons,
                                          input rv32i_types::rv32i_control_word prod);
        if (prod.rd_id == 5'd0)
        begin
            return 1'b0;
        end
        if (cons.opcode == rv32i_types::op_jalr)
        begin
            return prod.rd_id == cons.rs1_id;
        end
        return prod.rd_id == cons.rs1_id || prod.rd_id == cons.rs2_id;
    endfunction

    function automatic pipe_ctrl_pkg::stage_ctrl_t expected_ctrl();
        pipe_ctrl_pkg::stage_ctrl_t     e;
        rv32i_types::rv32i_control_word dec;
        logic                           alu_x;
        logic                           load_x;
        logic                           load_m;
        dec    = decode_ref(s_ifid);
        alu_x  = (arith_op(s_idex) && !set_less(s_idex)) || s_idex.opcode == rv32i_types::op_auipc;
        load_x = s_idex.opcode == rv32i_types::op_load;
        load_m = s_exmem.opcode == rv32i_types::op_load;
        e = '0;
        e.load_pc         = 1'b1;
        e.if_id_reg_load  = 1'b1;
        e.id_ex_reg_load  = 1'b1;
        e.ex_mem_reg_load = 1'b1;
        e.mem_wb_reg_load = 1'b1;
        if ((dec.opcode == rv32i_types::op_br || set_less(dec) ||
             dec.opcode == rv32i_types::op_jalr) &&
            (((alu_x || load_x) && reads_result(dec, s_idex)) ||
             (load_m && reads_result(dec, s_exmem))))
        begin
            e.load_pc         = 1'b0;
            e.if_id_reg_load  = 1'b0;
            e.id_ex_reg_flush = 1'b1;
        end
        if (load_m && ((alu_x && reads_result(s_idex, s_exmem)) ||
                       (s_idex.opcode == rv32i_types::op_store && s_exmem.rd_id != 5'd0 &&
                        s_exmem.rd_id == s_idex.rs1_id)))
        begin
            e.load_pc          = 1'b0;
            e.if_id_reg_load   = 1'b0;
            e.id_ex_reg_load   = 1'b0;
            e.ex_mem_reg_flush = 1'b1;
        end
        if ((dec.opcode == rv32i_types::op_br && br_en) ||
            dec.opcode == rv32i_types::op_jal || dec.opcode == rv32i_types::op_jalr)
        begin
            e.if_id_reg_flush = 1'b1;
        end
        // whole pipeline holds during a miss
        if (!instr_mem_resp || (!data_mem_resp && (s_exmem.mem_read || s_exmem.mem_write)))
        begin
            e = '0;
        end
        return e;
    endfunction

    // one cycle, entered and left 1 ns after a rising edge
    task automatic step();
        pipe_ctrl_pkg::stage_ctrl_t e;
        int                         rnd;
        rnd             = $random(seed);
        instr_mem_resp  = ((rnd & 32'h7fffffff) % 100) >= imiss_pct;
        rnd             = $random(seed);
        data_mem_resp   = ((rnd & 32'h7fffffff) % 100) >= dmiss_pct;
        instr           = imem[pc[7:2]];
        br_en           = br_taken;
        redirect_target = JUMP_TARGET;
        #2;
        e = expected_ctrl();
        check_value("stage_ctrl", 64'(stage_ctrl), 64'(e));
        check_value("pc", 64'(pc), 64'(s_pc));
        check_value("retire_ctrl", 64'(retire_ctrl), 64'(s_memwb));
        if (stage_ctrl.id_ex_reg_flush)
            id_ex_flushes++;
        if (stage_ctrl.ex_mem_reg_flush)
            ex_mem_flushes++;
        if (stage_ctrl.if_id_reg_flush)
            if_id_flushes++;
        if (!stage_ctrl.load_pc && !stage_ctrl.mem_wb_reg_load)
            hold_cycles++;
        if (retire_new && retire_ctrl != '0)
            retired.push_back(retire_ctrl);
        // advance the shadow, later stages first
        retire_new = e.mem_wb_reg_load || e.mem_wb_reg_flush;
        if (e.mem_wb_reg_flush)
            s_memwb = '0;
        else if (e.mem_wb_reg_load)
            s_memwb = s_exmem;
        if (e.ex_mem_reg_flush)
            s_exmem = '0;
        else if (e.ex_mem_reg_load)
            s_exmem = s_idex;
        if (e.id_ex_reg_flush)
            s_idex = '0;
        else if (e.id_ex_reg_load)
            s_idex = decode_ref(s_ifid);
        if (e.if_id_reg_flush)
            s_ifid = 32'h00000013;
        else if (e.if_id_reg_load)
            s_ifid = instr;
        if (e.if_id_reg_flush)
            s_pc = JUMP_TARGET;
        else if (e.load_pc)
            s_pc = s_pc + 32'd4;
        @(posedge clk);
        #1;
    endtask

    task automatic run_prog(input int n_cycles);
        @(posedge clk);
        #1;
        reset          = 1'b1;
        id_ex_flushes  = 0;
        ex_mem_flushes = 0;
        if_id_flushes  = 0;
        hold_cycles    = 0;
        retired.delete();
        s_pc       = RESET_PC;
        s_ifid     = 32'h00000013;
        s_idex     = '0;
        s_exmem    = '0;
        s_memwb    = '0;
        retire_new = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (n_cycles) step();
    endtask

    `include "hazard_tests.svh"

    initial
    begin
        reset           = 1'b1;
        instr           = 32'h00000013;
        instr_mem_resp  = 1'b1;
        data_mem_resp   = 1'b1;
        br_en           = 1'b0;
        redirect_target = JUMP_TARGET;
        br_taken        = 1'b0;
        imiss_pct       = 0;
        dmiss_pct       = 0;
        seed            = 80296;
        cycle_count     = 0;
        test_independent();
        test_decode_stalls();
        test_execute_stalls();
        test_redirects();
        test_misses();
        $display("Testbench passed");
        $finish;
    end

endmodule : hazard_core_tb

//--- list.f
hw/rv32i_types.sv
hw/pipe_ctrl_pkg.sv
hw/control_decoder.sv
hw/fetch_stage.sv
hw/control_pipeline.sv
hw/stall_control_unit.sv
hw/hazard_core_top.sv
+incdir+tb
tb/hazard_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hazard core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module hazard_core_tb -o hazard_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/hazard_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
